//--- Makefile
# Verilator build and run for the convolution pipe

VERILATOR ?= verilator
TOP ?= convolveTb
FLIST ?= flist.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)

//--- flist.f
src/convPkg.sv
src/satArith.sv
src/longShift.sv
src/scratchMemory.sv
src/convolvePipe.sv
src/convolveController.sv
src/convolveTop.sv
test/convolveTb.sv

//--- src/convPkg.sv
package convPkg;

	// Word types of the codec datapath
	typedef logic signed [15:0] word16;
	typedef logic signed [31:0] word32;
	typedef logic [11:0] memAddr;

	typedef struct packed {
		memAddr addr;
		word32 data;
		logic en;
	} memWrite;

	typedef struct packed {
		word32 acc;
		word16 a;
		word16 b;
	} macOperands;

	typedef struct packed {
		word32 value;
		word16 amount;
		logic ready;
	} shiftRequest;

	// Scratch memory layout
	localparam memAddr xBase = 12'd0;
	localparam memAddr hBase = 12'd256;
	localparam memAddr yBase = 12'd512;
	localparam int maxConvLen = 256;

	localparam word32 roundConst = 32'h00008000;
	localparam word32 wordMax = 32'h7fffffff;
	localparam word32 wordMin = 32'h80000000;

	typedef enum logic [3:0] {
		ctrlIdle,
		ctrlReadX,
		ctrlReadH,
		ctrlLatch,
		ctrlAccum,
		ctrlShift,
		ctrlShiftWait,
		ctrlRound,
		ctrlWrite,
		ctrlNext
	} ctrlState;

endpackage

//--- src/convolveController.sv
module convolveController
#(
	parameter int convLen = 40
)
(
	input logic clk,
	input logic rst,
	input logic start,
	input convPkg::word16 shiftAmt,
	output logic busy,
	output logic done,
	output convPkg::memAddr ctrlRdAddr,
	output convPkg::memWrite ctrlWr,
	output convPkg::macOperands macReq,
	input convPkg::word32 macSum,
	output convPkg::word32 roundIn,
	input convPkg::word32 roundSum,
	output convPkg::shiftRequest shiftReq,
	input convPkg::word32 shiftOut,
	input logic shiftDone,
	input convPkg::word32 rdData
);
	import convPkg::*;

	localparam int idxW = $clog2(maxConvLen);

	ctrlState state;
	logic [idxW-1:0] n;
	logic [idxW-1:0] i;
	word16 amtReg;
	word16 xReg;
	word16 hReg;
	word16 yHigh;
	word32 acc;

	////////////////////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ctrlIdle;
			done <= 1'b0;
			n <= '0;
			i <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				ctrlIdle:
					if (start)
					begin
						n <= '0;
						i <= '0;
						state <= ctrlReadX;
					end
				ctrlReadX: state <= ctrlReadH;
				ctrlReadH: state <= ctrlLatch;
				ctrlLatch: state <= ctrlAccum;
				// Inner loop over i = 0..n
				ctrlAccum:
					if (i == n)
						state <= ctrlShift;
					else
					begin
						i <= i + 1'b1;
						state <= ctrlReadX;
					end
				ctrlShift: state <= ctrlShiftWait;
				ctrlShiftWait:
					if (shiftDone)
						state <= ctrlRound;
				ctrlRound: state <= ctrlWrite;
				ctrlWrite: state <= ctrlNext;
				ctrlNext:
					if (n == convLen - 1)
					begin
						done <= 1'b1;
						state <= ctrlIdle;
					end
					else
					begin
						n <= n + 1'b1;
						i <= '0;
						state <= ctrlReadX;
					end
				default: state <= ctrlIdle;
			endcase
		end
	end

	// Operand and result registers
	always_ff @(posedge clk)
	begin
		case (state)
			ctrlIdle:
			begin
				acc <= '0;
				if (start)
					amtReg <= shiftAmt;
			end
			ctrlReadH: xReg <= rdData[15:0];
			ctrlLatch: hReg <= rdData[15:0];
			ctrlAccum: acc <= macSum;
			ctrlRound: yHigh <= roundSum[31:16];
			ctrlNext: acc <= '0;
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Requests to the pipe
	////////////////////////////////////////////////////////////////////////////

	assign busy = (state != ctrlIdle);

	// x address except while fetching h[n-i]
	always_comb
	begin
		ctrlRdAddr = xBase + memAddr'(i);
		if (state == ctrlReadH)
			ctrlRdAddr = hBase + memAddr'(n - i);
	end

	assign macReq = '{acc: acc, a: xReg, b: hReg};
	assign shiftReq = '{value: acc, amount: amtReg, ready: (state == ctrlShift)};
	assign roundIn = shiftOut;

	// High half, sign-extended
	assign ctrlWr = '{
		addr: yBase + memAddr'(n),
		data: {{16{yHigh[15]}}, yHigh},
		en: (state == ctrlWrite)
	};

	assert property (@(posedge clk) disable iff (rst)
		(start && !busy) |-> (shiftAmt >= 0 && shiftAmt <= 15));

endmodule

//--- src/convolvePipe.sv
module convolvePipe
(
	input logic clk,
	input logic rst,
	input convPkg::memAddr ctrlRdAddr,
	input convPkg::memWrite ctrlWr,
	input logic testRdSel,
	input convPkg::memAddr testRdAddr,
	input logic testWrSel,
	input convPkg::memWrite testWr,
	input convPkg::macOperands macReq,
	output convPkg::word32 macSum,
	input convPkg::word32 roundIn,
	output convPkg::word32 roundSum,
	input convPkg::shiftRequest shiftReq,
	output convPkg::word32 shiftOut,
	output logic shiftDone,
	output convPkg::word32 rdData
);
	import convPkg::*;

	memAddr rdAddrMux;
	memWrite wrMux;

	scratchMemory scratch (
		.clk(clk),
		.wr(wrMux),
		.rdAddr(rdAddrMux),
		.rdData(rdData)
	);

	satArith arith (
		.macReq(macReq),
		.macSum(macSum),
		.roundIn(roundIn),
		.roundSum(roundSum)
	);

	longShift shifter (
		.clk(clk),
		.rst(rst),
		.req(shiftReq),
		.result(shiftOut),
		.done(shiftDone)
	);

	////////////////////////////////////////////////////////////////////////////
	// Test port muxes
	////////////////////////////////////////////////////////////////////////////

	// Read address
	always_comb
	begin
		case (testRdSel)
			1'b0: rdAddrMux = ctrlRdAddr;
			1'b1: rdAddrMux = testRdAddr;
		endcase
	end

	// Whole write request, address, data and enable together
	always_comb
	begin
		case (testWrSel)
			1'b0: wrMux = ctrlWr;
			1'b1: wrMux = testWr;
		endcase
	end

	// Test port must not steal the memory during write-back
	assert property (@(posedge clk) disable iff (rst)
		ctrlWr.en |-> !testRdSel && !testWrSel);

endmodule

//--- src/convolveTop.sv
module convolveTop
#(
	parameter int convLen = 40
)
(
	input logic clk,
	input logic rst,
	input logic start,
	input convPkg::word16 shiftAmt,
	output logic busy,
	output logic done,
	input logic testRdSel,
	input convPkg::memAddr testRdAddr,
	input logic testWrSel,
	input convPkg::memWrite testWr,
	output convPkg::word32 rdData
);
	import convPkg::*;

	memAddr ctrlRdAddr;
	memWrite ctrlWr;
	macOperands macReq;
	word32 macSum;
	word32 roundIn;
	word32 roundSum;
	shiftRequest shiftReq;
	word32 shiftOut;
	logic shiftDone;

	convolveController #(
		.convLen(convLen)
	) ctrl (
		.clk(clk),
		.rst(rst),
		.start(start),
		.shiftAmt(shiftAmt),
		.busy(busy),
		.done(done),
		.ctrlRdAddr(ctrlRdAddr),
		.ctrlWr(ctrlWr),
		.macReq(macReq),
		.macSum(macSum),
		.roundIn(roundIn),
		.roundSum(roundSum),
		.shiftReq(shiftReq),
		.shiftOut(shiftOut),
		.shiftDone(shiftDone),
		.rdData(rdData)
	);

	convolvePipe pipe (
		.clk(clk),
		.rst(rst),
		.ctrlRdAddr(ctrlRdAddr),
		.ctrlWr(ctrlWr),
		.testRdSel(testRdSel),
		.testRdAddr(testRdAddr),
		.testWrSel(testWrSel),
		.testWr(testWr),
		.macReq(macReq),
		.macSum(macSum),
		.roundIn(roundIn),
		.roundSum(roundSum),
		.shiftReq(shiftReq),
		.shiftOut(shiftOut),
		.shiftDone(shiftDone),
		.rdData(rdData)
	);

endmodule

//--- src/longShift.sv
module longShift
(
	input logic clk,
	input logic rst,
	input convPkg::shiftRequest req,
	output convPkg::word32 result,
	output logic done
);
	import convPkg::*;

	logic active;
	logic accept;
	logic lastStep;
	logic [15:0] count;
	logic [15:0] remaining;

	// One bit left, clamps once the sign would flip
	function automatic word32 shiftOne(input word32 v);
		if (v[31] != v[30])
			return v[31] ? wordMin : wordMax;
		return v << 1;
	endfunction

	assign count = req.amount;
	assign accept = req.ready && !active;
	assign lastStep = active && (remaining == 16'd1);

	// First step happens on load
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			result <= (count == 16'd0) ? req.value : shiftOne(req.value);
			remaining <= count - 16'd1;
		end
		else if (active)
		begin
			result <= shiftOne(result);
			remaining <= remaining - 16'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			active <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= lastStep || (accept && count <= 16'd1);
			if (accept)
				active <= (count > 16'd1);
			else if (lastStep)
				active <= 1'b0;
		end
	end

	// Back-to-back done pulses need a fresh request
	assert property (@(posedge clk) disable iff (rst)
		(done && $past(done)) |-> $past(req.ready));

endmodule

//--- src/satArith.sv
module satArith
(
	input convPkg::macOperands macReq,
	output convPkg::word32 macSum,
	input convPkg::word32 roundIn,
	output convPkg::word32 roundSum
);
	import convPkg::*;

	word32 product;

	// 32-bit add, clamped on overflow
	function automatic word32 satAdd32(input word32 a, input word32 b);
		logic [32:0] wide;
		wide = {a[31], a} + {b[31], b};
		if (wide[32] != wide[31])
			return wide[32] ? wordMin : wordMax;
		return wide[31:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Multiply-accumulate
	////////////////////////////////////////////////////////////////////////////

	// Doubled product, only -32768 squared overflows
	always_comb
	begin
		if (macReq.a == 16'sh8000 && macReq.b == 16'sh8000)
			product = wordMax;
		else
			product = 2 * ($signed(macReq.a) * $signed(macReq.b));
	end

	assign macSum = satAdd32(macReq.acc, product);

	////////////////////////////////////////////////////////////////////////////
	// Rounding add
	////////////////////////////////////////////////////////////////////////////

	// Half an LSB of the high word
	assign roundSum = satAdd32(roundIn, roundConst);

endmodule

//--- src/scratchMemory.sv
module scratchMemory
(
	input logic clk,
	input convPkg::memWrite wr,
	input convPkg::memAddr rdAddr,
	output convPkg::word32 rdData
);
	import convPkg::*;

	localparam int depth = 2 ** $bits(memAddr);

	word32 mem [0:depth-1];

	// Write first in code, read still sees old word
	always_ff @(posedge clk)
	begin
		if (wr.en)
			mem[wr.addr] <= wr.data;
		rdData <= mem[rdAddr];
	end

endmodule

//--- test/convolveTb.sv
module convolveTb;
	import convPkg::*;

	localparam int convLen = 40;
	localparam int waitLimit = 20000;
	localparam longint posLimit = 64'sd2147483647;
	localparam longint negLimit = -64'sd2147483648;

	logic clk = 1'b0;
	logic rst;
	logic start;
	word16 shiftAmt;
	logic busy;
	logic done;
	logic testRdSel;
	memAddr testRdAddr;
	logic testWrSel;
	memWrite testWr;
	word32 rdData;

	int errorCount = 0;
	int timeoutCount = 0;
	word16 xVals [convLen];
	word16 hVals [convLen];

	convolveTop #(
		.convLen(convLen)
	) dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.shiftAmt(shiftAmt),
		.busy(busy),
		.done(done),
		.testRdSel(testRdSel),
		.testRdAddr(testRdAddr),
		.testWrSel(testWrSel),
		.testWr(testWr),
		.rdData(rdData)
	);

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic word32 clamp32(input longint v);
		if (v > posLimit)
			return 32'h7fffffff;
		if (v < negLimit)
			return 32'h80000000;
		return word32'(v);
	endfunction

	// High half of round(shl(sum of doubled products))
	function automatic word16 expectedY(input int n, input int amt);
		longint acc;
		longint prod;
		word32 rounded;
		acc = 0;
		for (int i = 0; i <= n; i++)
		begin
			if (xVals[i] == 16'sh8000 && hVals[n - i] == 16'sh8000)
				prod = posLimit;
			else
				prod = 2 * longint'(xVals[i]) * longint'(hVals[n - i]);
			acc = clamp32(acc + prod);
		end
		for (int s = 0; s < amt; s++)
			acc = clamp32(acc * 2);
		rounded = clamp32(acc + 64'sd32768);
		return rounded[31:16];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic checkWord(input word32 got, input word32 exp, input string what);
		if (got !== exp)
		begin
			errorCount++;
			$display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkSample(input word16 got, input word16 exp, input string what);
		if (got !== exp)
		begin
			errorCount++;
			$display("ERR %0t %s: got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			errorCount++;
			$display("ERR %0t %s: got %b, expected %b", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic writeWord(input memAddr wrAddr, input word32 wrData);
		@(posedge clk);
		testWr <= '{addr: wrAddr, data: wrData, en: 1'b1};
		testWrSel <= 1'b1;
		@(posedge clk);
		testWr.en <= 1'b0;
		testWrSel <= 1'b0;
	endtask

	// Data valid one cycle after the address
	task automatic readWord(input memAddr rdAddr, output word32 data);
		@(posedge clk);
		testRdSel <= 1'b1;
		testRdAddr <= rdAddr;
		@(posedge clk);
		@(negedge clk);
		data = rdData;
	endtask

	task automatic startPulse(input word16 amt);
		@(posedge clk);
		testRdSel <= 1'b0;
		testWrSel <= 1'b0;
		start <= 1'b1;
		shiftAmt <= amt;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic waitDone();
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < waitLimit)
		begin
			@(negedge clk);
			seen = done;
			cycles++;
		end
		if (!seen)
		begin
			timeoutCount++;
			$display("Timed out after %0d cycles waiting for done", waitLimit);
		end
	endtask

	task automatic runConv(input word16 amt);
		startPulse(amt);
		waitDone();
	endtask

	task automatic loadVectors();
		for (int i = 0; i < convLen; i++)
		begin
			writeWord(xBase + memAddr'(i), word32'(xVals[i]));
			writeWord(hBase + memAddr'(i), word32'(hVals[i]));
		end
	endtask

	task automatic checkOutputs(input int amt, input string what);
		word32 got;
		word16 exp;
		for (int n = 0; n < convLen; n++)
		begin
			readWord(yBase + memAddr'(n), got);
			exp = expectedY(n, amt);
			checkWord(got, word32'(exp), $sformatf("%s y[%0d]", what, n));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic controlTest();
		int extraDone;
		int busyHigh;
		word32 got;
		extraDone = 0;
		busyHigh = 0;
		// Nothing moves before the first start
		repeat (32)
		begin
			@(negedge clk);
			if (busy || done)
				busyHigh++;
		end
		checkFlag(busyHigh != 0, 1'b0, "busy or done before first start");
		busyHigh = 0;
		for (int i = 0; i < convLen; i++)
		begin
			xVals[i] = word16'(int'($urandom_range(511)) - 256);
			hVals[i] = word16'(int'($urandom_range(511)) - 256);
		end
		loadVectors();
		startPulse(16'sd3);
		@(negedge clk);
		checkFlag(busy, 1'b1, "busy after start");
		// Second start lands mid-run
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		waitDone();
		if (timeoutCount != 0)
			return;
		checkFlag(busy, 1'b0, "busy in done cycle");
		repeat (64)
		begin
			@(negedge clk);
			if (done)
				extraDone++;
			if (busy)
				busyHigh++;
		end
		checkFlag(extraDone != 0, 1'b0, "extra done after ignored start");
		checkFlag(busyHigh != 0, 1'b0, "busy after done");
		for (int i = 0; i < convLen; i++)
		begin
			readWord(xBase + memAddr'(i), got);
			checkSample(got[15:0], xVals[i], $sformatf("x[%0d] after run", i));
			readWord(hBase + memAddr'(i), got);
			checkSample(got[15:0], hVals[i], $sformatf("h[%0d] after run", i));
		end
		checkOutputs(3, "control");
	endtask

	// All writes land before the first read back
	task automatic memoryTest();
		word32 written [memAddr];
		memAddr addr;
		word32 data;
		word32 got;
		repeat (32)
		begin
			addr = memAddr'($urandom);
			data = word32'($urandom);
			writeWord(addr, data);
			written[addr] = data;
		end
		foreach (written[a])
		begin
			readWord(a, got);
			checkWord(got, written[a], $sformatf("test port word at %h", a));
		end
	endtask

	task automatic impulseTest();
		for (int i = 0; i < convLen; i++)
		begin
			xVals[i] = (i == 0) ? 16'sd16384 : 16'sd0;
			hVals[i] = word16'($urandom);
		end
		loadVectors();
		runConv(16'sd0);
		if (timeoutCount != 0)
			return;
		checkOutputs(0, "impulse");
	endtask

	task automatic randomTest();
		int amt;
		repeat (2)
		begin
			for (int i = 0; i < convLen; i++)
			begin
				xVals[i] = word16'(int'($urandom_range(4095)) - 2048);
				hVals[i] = word16'(int'($urandom_range(4095)) - 2048);
			end
			amt = int'($urandom_range(15));
			loadVectors();
			runConv(word16'(amt));
			if (timeoutCount != 0)
				return;
			checkOutputs(amt, $sformatf("random shift %0d", amt));
		end
	endtask

	// Most negative operands everywhere
	task automatic saturationTest();
		word32 got;
		for (int i = 0; i < convLen; i++)
		begin
			xVals[i] = 16'sh8000;
			hVals[i] = 16'sh8000;
		end
		loadVectors();
		runConv(16'sd4);
		if (timeoutCount != 0)
			return;
		for (int n = 0; n < convLen; n++)
		begin
			readWord(yBase + memAddr'(n), got);
			checkWord(got, 32'h00007fff, $sformatf("saturated y[%0d]", n));
		end
	endtask

	initial
	begin
		void'($urandom(32'h282b232b));
		rst = 1'b1;
		start = 1'b0;
		shiftAmt = '0;
		testRdSel = 1'b0;
		testRdAddr = '0;
		testWrSel = 1'b0;
		testWr = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		controlTest();
		if (timeoutCount == 0)
			memoryTest();
		if (timeoutCount == 0)
			impulseTest();
		if (timeoutCount == 0)
			randomTest();
		if (timeoutCount == 0)
			saturationTest();
		$display("errors %0d, timeouts %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
